// File: design/hr_signal_pkg.sv
package hr_signal_pkg;

  ////////////////////
  // sample path

  localparam int SAMPLE_W  = 8;   // adc word
  localparam int AVG_TAPS  = 8;   // moving-average window
  localparam int AVG_SHIFT = 3;   // log2(AVG_TAPS)

  localparam int PEAK_HIGH = 160; // beat threshold
  localparam int PEAK_LOW  = 96;  // re-arm level, gives the hysteresis

  ////////////////////
  // beat interval and rate

  localparam int INTERVAL_W    = 11;   // saturates at 2047 samples
  localparam int MIN_INTERVAL  = 30;   // 200 bpm, anything closer is noise
  localparam int MAX_INTERVAL  = 300;  // 20 bpm, slower is a lost signal
  localparam int BPM_NUMERATOR = 6000; // samples per minute at 100 Hz
  localparam int DIV_STEPS     = 12;   // quotient bits, one per cycle
  localparam int BPM_W         = 8;

  localparam int HISTORY_LEN   = 16;   // readings averaged
  localparam int HISTORY_SHIFT = 4;
  localparam int HR_MIN        = 50;   // shown window
  localparam int HR_MAX        = 110;

  typedef struct packed {
    logic                strobe;
    logic [SAMPLE_W-1:0] data;
  } sample_t;

  typedef struct packed {
    logic                  strobe;
    logic [INTERVAL_W-1:0] count;  // samples between beats
  } interval_t;

  typedef struct packed {
    logic             strobe;
    logic [BPM_W-1:0] value;
  } bpm_t;

endpackage

// File: design/hr_ui_pkg.sv
package hr_ui_pkg;

  // same codes as the old system_status register
  typedef enum logic [1:0] {
    PAUSED  = 2'd0,
    RUN     = 2'd1,
    ERROR   = 2'd2,
    STARTUP = 2'd3
  } status_t;

  // debounced, synchronized levels
  typedef struct packed {
    logic up;    // -> error
    logic down;  // -> run
    logic left;  // -> pause
  } btn_t;

  typedef struct packed {
    logic red;
    logic green;
    logic blue;
  } rgb_t;

  localparam int BOOT_TICKS = 300;  // 3 s of samples

endpackage

// File: design/pulse_lowpass.sv
`timescale 1ns/100ps

module pulse_lowpass import hr_signal_pkg::*; (
  input  logic                clk_100hz,
  input  logic                master_reset,
  input  logic [SAMPLE_W-1:0] sensor_pins,  // connector order, not bit order
  input  logic                adc_done,     // one-cycle conversion strobe
  output sample_t             filtered
);

  logic [SAMPLE_W-1:0]           restored;
  logic [SAMPLE_W-1:0]           window [AVG_TAPS];  // [0] newest
  logic [SAMPLE_W+AVG_SHIFT-1:0] sum;                // sum of the window
  logic [SAMPLE_W+AVG_SHIFT-1:0] sum_next;

  // header wiring interleaves the two nibbles
  assign restored = {sensor_pins[7], sensor_pins[3], sensor_pins[6], sensor_pins[2],
                     sensor_pins[5], sensor_pins[1], sensor_pins[4], sensor_pins[0]};

  // running sum, oldest drops out as newest comes in
  // never underflows, oldest sample is always part of sum
  assign sum_next = sum + {{AVG_SHIFT{1'b0}}, restored}
                        - {{AVG_SHIFT{1'b0}}, window[AVG_TAPS-1]};

  always_ff @(posedge clk_100hz) begin
    if (master_reset) begin
      for (int i = 0; i < AVG_TAPS; i++) begin
        window[i] <= '0;  // average starts from a flat zero history
      end
      sum      <= '0;
      filtered <= '0;
    end else begin
      filtered.strobe <= adc_done;  // one cycle behind the adc
      if (adc_done) begin
        for (int i = AVG_TAPS-1; i > 0; i--) begin
          window[i] <= window[i-1];
        end
        window[0]     <= restored;
        sum           <= sum_next;
        filtered.data <= sum_next[SAMPLE_W+AVG_SHIFT-1:AVG_SHIFT];  // floor(sum/8)
      end
    end
  end

endmodule

// File: design/beat_detector.sv
`timescale 1ns/100ps

module beat_detector import hr_signal_pkg::*; (
  input  logic      clk_100hz,
  input  logic      master_reset,
  input  sample_t   filtered,
  output logic      beat,      // one pulse per accepted beat
  output interval_t interval   // samples since the previous beat
);

  logic                  armed;     // waiting for a rising crossing
  logic                  have_prev; // a beat was seen since reset
  logic [INTERVAL_W-1:0] count;     // strobes since last accepted beat
  logic [INTERVAL_W-1:0] count_inc;
  logic                  crossing;

  // saturating, a lost signal parks the count at 2047
  assign count_inc = (count == '1) ? count : count + 1'b1;

  assign crossing = armed && (filtered.data > PEAK_HIGH);

  always_ff @(posedge clk_100hz) begin
    if (master_reset) begin
      armed     <= 1'b1;
      have_prev <= 1'b0;
      count     <= '0;
      beat      <= 1'b0;
      interval  <= '0;
    end else begin
      beat            <= 1'b0;
      interval.strobe <= 1'b0;

      if (filtered.strobe) begin
        if (crossing) begin
          armed <= 1'b0;  // need a dip below PEAK_LOW first
          if (count_inc < MIN_INTERVAL) begin
            count <= count_inc;  // too soon, treat as noise
          end else begin
            beat      <= 1'b1;
            count     <= '0;
            have_prev <= 1'b1;
            // first beat has no interval, long gaps are dropped
            interval.strobe <= have_prev && (count_inc <= MAX_INTERVAL);
            interval.count  <= count_inc;
          end
        end else begin
          count <= count_inc;
          if (filtered.data < PEAK_LOW) begin
            armed <= 1'b1;  // re-arm on the valley
          end
        end
      end
    end
  end

endmodule

// File: design/bpm_divider.sv
`timescale 1ns/100ps

module bpm_divider import hr_signal_pkg::*; (
  input  logic      clk_100hz,
  input  logic      master_reset,
  input  interval_t interval,
  output bpm_t      bpm        // floor(6000 / interval)
);

  logic [DIV_STEPS:0]           numer;    // 13 bits holds 6000
  logic                         busy;
  logic [$clog2(DIV_STEPS)-1:0] bit_idx;  // next quotient bit
  logic [INTERVAL_W:0]          rem;      // partial remainder
  logic [INTERVAL_W-1:0]        divisor;
  logic [DIV_STEPS-1:0]         quot;

  logic [INTERVAL_W:0]          rem_in;
  logic [INTERVAL_W-1:0]        div_in;
  logic [INTERVAL_W+1:0]        trial;
  logic [INTERVAL_W:0]          rem_next;
  logic                         q_bit;
  logic [DIV_STEPS-1:0]         quot_next;

  assign numer = BPM_NUMERATOR[DIV_STEPS:0];

  ////////////////////
  // one restoring step
  // load cycle already does bit 11, so the result lands 12 cycles later
  // top numerator bit preloads the remainder as q[12] is 0 for interval >= 2
  assign rem_in = busy ? rem : {{INTERVAL_W{1'b0}}, numer[DIV_STEPS]};
  assign div_in = busy ? divisor : interval.count;
  assign trial  = {rem_in, numer[busy ? bit_idx : 4'(DIV_STEPS-1)]};
  assign q_bit  = trial >= {2'b00, div_in};
  assign rem_next  = q_bit ? (INTERVAL_W+1)'(trial - {2'b00, div_in})
                           : trial[INTERVAL_W:0];
  assign quot_next = {quot[DIV_STEPS-2:0], q_bit};

  always_ff @(posedge clk_100hz) begin
    if (master_reset) begin
      busy    <= 1'b0;
      bit_idx <= '0;
      bpm     <= '0;
    end else begin
      bpm.strobe <= 1'b0;
      if (!busy) begin
        if (interval.strobe) begin  // intervals during a division are lost
          busy    <= 1'b1;
          bit_idx <= 4'(DIV_STEPS-2);
        end
      end else if (bit_idx == '0) begin
        busy       <= 1'b0;
        bpm.strobe <= 1'b1;
        // intervals of 30 or more cap this at 200
        bpm.value  <= (quot_next > 255) ? '1 : quot_next[BPM_W-1:0];
      end else begin
        bit_idx <= bit_idx - 1'b1;
      end
    end
  end

  // divider datapath
  always_ff @(posedge clk_100hz) begin
    if (!busy && interval.strobe) begin
      divisor <= interval.count;
      rem     <= rem_next;
      quot    <= {{(DIV_STEPS-1){1'b0}}, q_bit};
    end else if (busy) begin
      rem  <= rem_next;
      quot <= quot_next;
    end
  end

endmodule

// File: design/hr_averager.sv
`timescale 1ns/100ps

module hr_averager
  import hr_signal_pkg::*;
  import hr_ui_pkg::*;
(
  input  logic             clk_100hz,
  input  logic             master_reset,
  input  bpm_t             bpm,
  input  status_t          status,
  input  logic             clamp_en,    // limit shown value to 50..110
  output logic [BPM_W-1:0] hr_average,
  output logic [BPM_W-1:0] hr_shown
);

  logic [BPM_W-1:0]               history [HISTORY_LEN];  // [0] newest
  logic [BPM_W+HISTORY_SHIFT-1:0] sum;                    // 12 bits, 16 x 255 fits
  logic [BPM_W+HISTORY_SHIFT-1:0] sum_next;
  logic [BPM_W-1:0]               avg_next;
  logic [BPM_W-1:0]               clamped;

  ////////////////////
  // running sum of the last 16 readings

  assign sum_next = sum + {{HISTORY_SHIFT{1'b0}}, bpm.value}
                        - {{HISTORY_SHIFT{1'b0}}, history[HISTORY_LEN-1]};
  assign avg_next = sum_next[BPM_W+HISTORY_SHIFT-1:HISTORY_SHIFT];  // floor(sum/16)

  // keeps a bad pickup from showing silly rates
  always_comb begin
    if (avg_next > HR_MAX) begin
      clamped = BPM_W'(HR_MAX);
    end else if (avg_next < HR_MIN) begin
      clamped = BPM_W'(HR_MIN);
    end else begin
      clamped = avg_next;
    end
  end

  always_ff @(posedge clk_100hz) begin
    if (master_reset) begin
      for (int i = 0; i < HISTORY_LEN; i++) begin
        history[i] <= '0;  // average ramps up from zero
      end
      sum        <= '0;
      hr_average <= '0;
      hr_shown   <= '0;
    end else if (bpm.strobe) begin
      for (int i = HISTORY_LEN-1; i > 0; i--) begin
        history[i] <= history[i-1];
      end
      history[0] <= bpm.value;
      sum        <= sum_next;
      hr_average <= avg_next;
      if (clamp_en && status != PAUSED) begin
        hr_shown <= clamped;  // frozen while paused
      end
    end
  end

endmodule

// File: design/monitor_status_fsm.sv
`timescale 1ns/100ps

module monitor_status_fsm import hr_ui_pkg::*; (
  input  logic    clk_100hz,
  input  logic    master_reset,
  input  btn_t    btn,          // debounced levels
  output status_t status,
  output rgb_t    led
);

  btn_t                          btn_prev;
  btn_t                          rise;      // 0 -> 1 since last cycle
  logic [$clog2(BOOT_TICKS)-1:0] boot_cnt;

  assign rise = btn & ~btn_prev;

  always_ff @(posedge clk_100hz) begin
    if (master_reset) begin
      status   <= STARTUP;
      boot_cnt <= '0;
      btn_prev <= '0;
    end else begin
      btn_prev <= btn;  // track edges during startup too
      if (status == STARTUP) begin
        // buttons ignored until boot is done
        if (boot_cnt == BOOT_TICKS-1) begin
          status   <= RUN;
          boot_cnt <= '0;
        end else begin
          boot_cnt <= boot_cnt + 1'b1;
        end
      end else if (rise.down) begin
        status <= RUN;     // wins over left and up
      end else if (rise.left) begin
        status <= PAUSED;
      end else if (rise.up) begin
        status <= ERROR;
      end
    end
  end

  ////////////////////
  // state colour

  always_comb begin
    led = '0;
    case (status)
      STARTUP: led.red   = 1'b1;
      RUN:     led.green = 1'b1;
      PAUSED:  led.blue  = 1'b1;
      ERROR: begin
        led.red  = 1'b1;   // magenta
        led.blue = 1'b1;
      end
      default: led = '0;
    endcase
  end

endmodule

// File: design/heart_monitor_top.sv
`timescale 1ns/100ps

module heart_monitor_top
  import hr_signal_pkg::*;
  import hr_ui_pkg::*;
(
  input  logic                clk_100hz,    // sample clock, whole design
  input  logic                master_reset,
  input  logic [SAMPLE_W-1:0] sensor_pins,  // scrambled adc bits
  input  logic                adc_done,
  input  btn_t                btn,
  input  logic                clamp_en,
  output logic                beat,
  output logic [BPM_W-1:0]    hr_average,
  output logic [BPM_W-1:0]    hr_shown,
  output status_t             status,
  output rgb_t                led
);

  sample_t   filtered;   // lowpass -> detector
  interval_t interval;   // detector -> divider
  bpm_t      bpm;        // divider -> averager

  ////////////////////
  // rate chain

  pulse_lowpass u_lowpass (
    .clk_100hz    (clk_100hz),
    .master_reset (master_reset),
    .sensor_pins  (sensor_pins),
    .adc_done     (adc_done),
    .filtered     (filtered)
  );

  beat_detector u_detector (
    .clk_100hz    (clk_100hz),
    .master_reset (master_reset),
    .filtered     (filtered),
    .beat         (beat),
    .interval     (interval)
  );

  bpm_divider u_divider (
    .clk_100hz    (clk_100hz),
    .master_reset (master_reset),
    .interval     (interval),
    .bpm          (bpm)
  );

  hr_averager u_averager (
    .clk_100hz    (clk_100hz),
    .master_reset (master_reset),
    .bpm          (bpm),
    .status       (status),       // pause freezes the shown rate
    .clamp_en     (clamp_en),
    .hr_average   (hr_average),
    .hr_shown     (hr_shown)
  );

  ////////////////////
  // user interface

  monitor_status_fsm u_status (
    .clk_100hz    (clk_100hz),
    .master_reset (master_reset),
    .btn          (btn),
    .status       (status),
    .led          (led)
  );

endmodule

// File: sim/hr_tb_tasks.svh
////////////////////
// reference model state

int      win_q[$];     // last 8 restored samples, newest first
int      win_sum;
bit      m_armed;
bit      m_have_prev;
int      m_count;      // samples since last accepted beat
int      hist_q[$];    // last 16 rates, newest first
int      hist_sum;
int      m_avg;
int      m_shown;
status_t exp_status;
bit      last_beat;    // beat seen for the latest sample

task automatic model_reset();
  win_q = {};
  hist_q = {};
  repeat (AVG_TAPS) win_q.push_back(0);
  repeat (HISTORY_LEN) hist_q.push_back(0);
  win_sum     = 0;
  hist_sum    = 0;
  m_armed     = 1'b1;
  m_have_prev = 1'b0;
  m_count     = 0;
  m_avg       = 0;
  m_shown     = 0;
  exp_status  = STARTUP;
endtask

// sample bits 7..0 sit on pins 7,3,6,2,5,1,4,0
function automatic logic [7:0] scramble(input logic [7:0] s);
  logic [7:0] p;
  p[7] = s[7];
  p[3] = s[6];
  p[6] = s[5];
  p[2] = s[4];
  p[5] = s[3];
  p[1] = s[2];
  p[4] = s[1];
  p[0] = s[0];
  return p;
endfunction

function automatic rgb_t led_for(input status_t s);
  case (s)
    STARTUP: return 3'b100;  // red
    RUN:     return 3'b010;  // green
    PAUSED:  return 3'b001;  // blue
    default: return 3'b101;  // error shows red and blue
  endcase
endfunction

task automatic report_mismatch(input string what, input int expected, input int actual);
  mismatches++;
  $display("Fail %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
endtask

task automatic report_problem(input string what);
  problems++;
  $display("Error in %s: %s", test_name, what);
endtask

// new rate into the 16 deep history, clamp only when running
task automatic model_rate(input int rate);
  hist_sum = hist_sum + rate - hist_q[HISTORY_LEN-1];
  void'(hist_q.pop_back());
  hist_q.push_front(rate);
  m_avg = hist_sum / HISTORY_LEN;
  if (clamp_en && exp_status != PAUSED) begin
    m_shown = (m_avg > HR_MAX) ? HR_MAX : ((m_avg < HR_MIN) ? HR_MIN : m_avg);
  end
endtask

////////////////////
// drive and check

// waits for the divider result, or makes sure none comes
task automatic check_rate(input bit expect_rate, input int rate);
  int waited;
  waited = 0;
  while (!uut.bpm.strobe && waited < 20) begin
    @(negedge clk_100hz);
    waited++;
  end
  if (expect_rate && !uut.bpm.strobe) begin
    report_problem("no rate result after an accepted interval");
  end else if (!expect_rate && uut.bpm.strobe) begin
    report_problem("rate result for an interval that should be dropped");
  end else if (expect_rate) begin
    if (uut.bpm.value !== rate) report_mismatch("bpm", rate, uut.bpm.value);
    model_rate(rate);
    @(negedge clk_100hz);  // outputs move one cycle after the strobe
  end
  if (hr_average !== m_avg) report_mismatch("hr_average", m_avg, hr_average);
  if (hr_shown !== m_shown) report_mismatch("hr_shown", m_shown, hr_shown);
endtask

task automatic feed_sample(input int value);
  int avg;
  int next_cnt;
  bit exp_beat;
  bit exp_rate;
  int exp_bpm;
  // moving average of the restored samples
  win_sum = win_sum + value - win_q[AVG_TAPS-1];
  void'(win_q.pop_back());
  win_q.push_front(value);
  avg      = win_sum / AVG_TAPS;
  next_cnt = (m_count == 2047) ? m_count : m_count + 1;
  exp_beat = 1'b0;
  exp_rate = 1'b0;
  exp_bpm  = 0;
  if (m_armed && avg > PEAK_HIGH) begin
    m_armed = 1'b0;
    if (next_cnt < MIN_INTERVAL) begin
      m_count = next_cnt;  // too close, noise
    end else begin
      exp_beat    = 1'b1;
      exp_rate    = m_have_prev && next_cnt <= MAX_INTERVAL;
      exp_bpm     = BPM_NUMERATOR / next_cnt;
      m_count     = 0;
      m_have_prev = 1'b1;
    end
  end else begin
    m_count = next_cnt;
    if (avg < PEAK_LOW) m_armed = 1'b1;
  end
  @(posedge clk_100hz);
  sensor_pins <= scramble(value[7:0]);
  adc_done    <= 1'b1;
  @(posedge clk_100hz);
  adc_done <= 1'b0;
  @(negedge clk_100hz);
  if (uut.filtered.strobe !== 1'b1) report_problem("no filtered strobe after adc_done");
  if (uut.filtered.data !== avg) report_mismatch("filtered", avg, uut.filtered.data);
  @(posedge clk_100hz);
  @(negedge clk_100hz);
  last_beat = beat;
  if (beat !== exp_beat) report_mismatch("beat", exp_beat, beat);
  if (exp_beat) check_rate(exp_rate, exp_bpm);
endtask

task automatic press_buttons(input logic up, input logic down, input logic left,
                             input status_t expected);
  @(posedge clk_100hz);
  btn <= {up, down, left};
  @(posedge clk_100hz);  // edge seen here
  @(negedge clk_100hz);
  if (status !== expected) report_mismatch("status", expected, status);
  if (led !== led_for(expected)) report_mismatch("led", led_for(expected), led);
  @(posedge clk_100hz);
  btn <= '0;
  exp_status = expected;
endtask

// File: sim/heart_monitor_tb.sv
`timescale 1ns/100ps

module heart_monitor_tb
  import hr_signal_pkg::*;
  import hr_ui_pkg::*;
();

  logic                clk_100hz;
  logic                master_reset;
  logic [SAMPLE_W-1:0] sensor_pins;
  logic                adc_done;
  btn_t                btn;
  logic                clamp_en;
  logic                beat;
  logic [BPM_W-1:0]    hr_average;
  logic [BPM_W-1:0]    hr_shown;
  status_t             status;
  rgb_t                led;

  int     mismatches;  // wrong values
  int     problems;    // timeouts, missing or extra events
  string  test_name;
  integer seed;        // sample noise

  heart_monitor_top uut (.*);

  always #50 clk_100hz = ~clk_100hz;  // 100 ns

  `include "hr_tb_tasks.svh"

  // pulse of 255 for 10 samples, noise otherwise, optional 8 sample spike
  task automatic run_pulses(input int period, input int periods, input int spike_at);
    int  value;
    int  p;
    int  i;
    bit  in_spike;
    for (p = 0; p < periods; p++) begin
      for (i = 0; i < period; i++) begin
        in_spike = spike_at > 0 && i >= spike_at && i < spike_at + 8;
        value = (i < 10 || in_spike) ? 255 : 8 + ($random(seed) & 15);
        feed_sample(value);
        if (spike_at > 0 && i >= spike_at && i < spike_at + 10 && last_beat) begin
          report_problem("beat on a spike too close to the previous beat");
        end
      end
    end
  endtask

  ////////////////////
  // directed tests

  task automatic test_reset_startup();
    int waited;
    test_name = "reset_startup";
    @(negedge clk_100hz);
    if (status !== STARTUP) report_mismatch("status", STARTUP, status);
    if (led !== led_for(STARTUP)) report_mismatch("led", led_for(STARTUP), led);
    if (hr_average !== 0) report_mismatch("hr_average", 0, hr_average);
    if (hr_shown !== 0) report_mismatch("hr_shown", 0, hr_shown);
    press_buttons(1'b1, 1'b0, 1'b0, STARTUP);  // ignored while booting
    press_buttons(1'b0, 1'b1, 1'b0, STARTUP);
    press_buttons(1'b0, 1'b0, 1'b1, STARTUP);
    waited = 0;
    while (status !== RUN && waited < BOOT_TICKS + 50) begin
      @(negedge clk_100hz);
      waited++;
    end
    if (status !== RUN) report_problem("status never left STARTUP");
    if (led !== led_for(RUN)) report_mismatch("led", led_for(RUN), led);
    exp_status = RUN;
  endtask

  task automatic test_buttons();
    test_name = "buttons";
    press_buttons(1'b0, 1'b0, 1'b1, PAUSED);
    press_buttons(1'b1, 1'b0, 1'b0, ERROR);
    press_buttons(1'b0, 1'b1, 1'b0, RUN);
    press_buttons(1'b0, 1'b0, 1'b1, PAUSED);
    press_buttons(1'b0, 1'b1, 1'b1, RUN);  // down beats left
  endtask

  task automatic test_beat_timing();
    test_name = "beat_timing";
    run_pulses(60, 3, 0);
    run_pulses(60, 3, 25);  // spike 20 samples after the beat
  endtask

  task automatic test_rate_average();
    test_name = "rate_average";
    run_pulses(60, 18, 0);
    if (hr_average !== 100) report_mismatch("converged average", 100, hr_average);
    run_pulses(350, 2, 0);  // too slow to give an update
    if (hr_average !== 100) report_mismatch("average after long gaps", 100, hr_average);
  endtask

  task automatic test_clamp_pause();
    int held;
    int avg_before;
    test_name = "clamp_pause";
    @(posedge clk_100hz);
    clamp_en <= 1'b1;
    run_pulses(40, 18, 0);  // 150 bpm
    if (hr_shown !== HR_MAX) report_mismatch("clamped hr_shown", HR_MAX, hr_shown);
    press_buttons(1'b0, 1'b0, 1'b1, PAUSED);
    held       = m_shown;
    avg_before = m_avg;
    run_pulses(60, 4, 0);
    if (hr_shown !== held) report_mismatch("paused hr_shown", held, hr_shown);
    if (hr_average == avg_before) report_problem("average frozen while paused");
    press_buttons(0, 1'b1, 1'b0, RUN);
    @(posedge clk_100hz);
    clamp_en <= 1'b0;
    avg_before = m_avg;
    run_pulses(60, 4, 0);
    if (hr_shown !== held) report_mismatch("unclamped hr_shown", held, hr_shown);
    if (hr_average == avg_before) report_problem("average frozen with clamp off");
  endtask

  initial begin
    seed         = 32'hddc6_f539;
    clk_100hz    = 1'b0;
    master_reset = 1'b1;
    sensor_pins  = '0;
    adc_done     = 1'b0;
    btn          = '0;
    clamp_en     = 1'b0;
    mismatches   = 0;
    problems     = 0;
    test_name    = "reset";
    model_reset();
    repeat (5) @(posedge clk_100hz);
    master_reset <= 1'b0;
    test_reset_startup();
    test_buttons();
    test_beat_timing();
    test_rate_average();
    test_clamp_pause();
    $display("summary: %0d wrong values, %0d other failures", mismatches, problems);
    if (mismatches == 0 && problems == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: heart_monitor.f
+incdir+sim
design/hr_signal_pkg.sv
design/hr_ui_pkg.sv
design/pulse_lowpass.sv
design/beat_detector.sv
design/bpm_divider.sv
design/hr_averager.sv
design/monitor_status_fsm.sv
design/heart_monitor_top.sv
sim/heart_monitor_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= heart_monitor_tb
FILELIST  ?= heart_monitor.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal
PASS_TEXT ?= *** PASSED ***

SOURCES := $(wildcard design/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
